// ==== list.f ====
+incdir+.
arcade_input_pkg.sv
control_capture.sv
input_port_mapper.sv
port_output_stage.sv
arcade_input_top.sv
arcade_input_properties.sv
tb_arcade_input.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_arcade_input
RTL_TOP    ?= arcade_input_top
FILE_LIST  ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_arcade_input.sv ====
`timescale 1ns/100ps
`include "arcade_input_defs.svh"

module tb_arcade_input
	import arcade_input_pkg::*;
();

	// Tests take about 1000 cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic                     clk_sys;
	logic                     rst;
	logic [`AI_USB_JOY_W-1:0] usb_joy1;
	logic [`AI_USB_JOY_W-1:0] usb_joy2;
	logic [`AI_DB_JOY_W-1:0]  db_joy1;
	logic [`AI_DB_JOY_W-1:0]  db_joy2;
	db_mode_t                 db_mode;
	logic                     db_two_players;
	logic                     alt_fire_mode;
	dl_write_t                dl;
	io_ports_t                ports;
	board_flags_t             flags;

	// Expected state
	game_id_t              model_game;
	logic [`AI_PORT_W-1:0] model_dip [4];
	io_ports_t             ports_before;
	board_flags_t          flags_before;
	int                    port_errors = 0;
	int                    flag_errors = 0;
	int                    cycles = 0;

	arcade_input_top u_dut (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.usb_joy1       (usb_joy1),
		.usb_joy2       (usb_joy2),
		.db_joy1        (db_joy1),
		.db_joy2        (db_joy2),
		.db_mode        (db_mode),
		.db_two_players (db_two_players),
		.alt_fire_mode  (alt_fire_mode),
		.dl             (dl),
		.ports          (ports),
		.flags          (flags)
	);

	initial
	begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	// ============================================================
	// Expected values
	// ============================================================

	// DB word in USB bit order, player 2 swaps bits 9 and 10
	function automatic logic [10:0] db_to_usb(input logic [15:0] w, input logic second);
		logic [10:0] u;
		u[7:0] = w[7:0];
		u[8]   = second ? w[9] : w[10];
		u[9]   = second ? w[10] : w[9];
		u[10]  = w[11] | (w[10] & w[5]);
		return u;
	endfunction

	function automatic logic [10:0] merged_controls();
		logic [10:0] p1;
		logic [10:0] p2;
		if (db_mode == db_off)
		begin
			p1 = usb_joy1[10:0];
			p2 = usb_joy2[10:0];
		end
		else
		begin
			p1 = db_to_usb(db_joy1, 1'b0);
			p2 = db_two_players ? db_to_usb(db_joy2, 1'b1) : usb_joy1[10:0];
		end
		return p1 | p2;
	endfunction

	// Bits of c: R L D U F1 F2 F3 F4 S1/F5 S2 CO from 0 to 10
	function automatic io_ports_t expected_ports(input game_id_t g);
		logic [10:0] c;
		io_ports_t   h;
		c = merged_controls();
		h.pa = {c[10], 1'b0, c[1], c[0], c[4], 1'b0, c[5], c[3]};
		h.pb = {c[8], c[9], c[1], c[0], c[4], c[5], 2'b00};
		h.pc = {1'b0, c[2], 1'b0, c[3], 3'b000, c[2]};
		h.pd = '0;
		case (g)
			game_tazman:
			begin
				h.pa = {c[10], 1'b0, c[1], c[0], c[2], c[3], c[4], c[5]};
				h.pb = '0;
				h.pc = {1'b0, c[9], 5'b00000, c[8]};
			end
			game_calipso:
			begin
				h.pa = {c[10], 1'b0, c[1], c[0], c[2], c[3], 1'b0, c[9] | c[4]};
				h.pb = {2'b00, c[1], c[0], c[2], c[3], 2'b00};
				h.pc = {7'b0000000, c[4] | c[8]};
			end
			game_anteater:
			begin
				h.pa = {c[10], 1'b0, c[1], c[0], c[2], c[3], 1'b0, c[4]};
				h.pb = {1'b0, c[4], c[1], c[0], c[3], c[2], 2'b00};
				h.pc = {1'b0, c[9], 5'b00000, c[8]};
			end
			game_losttomb:
			begin
				h.pa = {c[10], 1'b0, c[1], c[0], c[2], c[3], c[8], c[9]};
				h.pb = alt_fire_mode ? {1'b0, c[8] | c[4], c[1], c[0], c[2], c[3], 2'b00}
					: {1'b0, c[8], c[7], c[4], c[5], c[6], 2'b00};
				h.pc = '0;
			end
			game_minefld,
			game_rescue:
			begin
				h.pa = {c[10], 1'b0, c[1], c[0], c[2], c[3], 1'b0, c[8]};
				h.pb = alt_fire_mode ? {2'b00, c[1], c[0], c[2], c[3], 2'b00}
					: {2'b00, c[7], c[4], c[5], c[6], 2'b00};
				h.pc = {1'b0, c[9], 5'b00000, c[8]};
			end
			default:
			begin
				// Games without a port layout here are checked with the controls released
			end
		endcase
		expected_ports.pa = ~h.pa & model_dip[0];
		expected_ports.pb = ~h.pb & model_dip[1];
		expected_ports.pc = ~h.pc & model_dip[2];
		expected_ports.pd = ~h.pd & model_dip[3];
	endfunction

	// Packed as hwsel, landscape, four_fire, galaxian_video
	function automatic board_flags_t expected_flags(input game_id_t g);
		case (g)
			game_frogger:  return {8'd1, 3'b000};
			game_scobra,
			game_armorcar,
			game_tazman:   return {8'd2, 3'b000};
			game_calipso:  return {8'd3, 3'b000};
			game_anteater: return {8'd6, 3'b000};
			game_losttomb: return {8'd7, 3'b010};
			game_theend:   return {8'd0, 3'b001};
			game_stratgyx: return {8'd5, 3'b100};
			game_turtles:  return {8'd11, 3'b000};
			game_minefld:  return {8'd8, 3'b010};
			game_rescue:   return {8'd9, 3'b010};
			game_mimonkey: return {8'd12, 3'b000};
			default:       return '0;
		endcase
	endfunction

	// ============================================================
	// Compare and drive helpers
	// ============================================================
	task automatic check_ports(input string ctx, input io_ports_t got, input io_ports_t want);
		if (got !== want)
		begin
			port_errors++;
			$display("mismatch at %0t: ports (%s) got %h expected %h", $time, ctx, got, want);
		end
	endtask

	task automatic check_flags(input string ctx, input board_flags_t got,
		input board_flags_t want);
		if (got !== want)
		begin
			flag_errors++;
			$display("mismatch at %0t: flags (%s) got %h expected %h", $time, ctx, got, want);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic snapshot();
		ports_before = expected_ports(model_game);
		flags_before = expected_flags(model_game);
	endtask

	task automatic write_dl(input logic [7:0] index, input logic [`AI_DL_ADDR_W-1:0] addr,
		input logic [7:0] data);
		dl.wr    = 1'b1;
		dl.index = index;
		dl.addr  = addr;
		dl.data  = data;
		if (index == 8'(`AI_DL_INDEX_GAME))
			model_game = game_id_t'(data);
		else if (index == 8'(`AI_DL_INDEX_DIP) && addr < 25'd4)
			model_dip[addr[1:0]] = data;
	endtask

	// Old values for one cycle, new ones in the second
	task automatic settle_and_check(input string ctx, input logic exact);
		next_cycle();
		dl.wr = 1'b0;
		if (exact)
		begin
			check_ports({ctx, ", first cycle"}, ports, ports_before);
			check_flags({ctx, ", first cycle"}, flags, flags_before);
		end
		next_cycle();
		check_ports(ctx, ports, expected_ports(model_game));
		check_flags(ctx, flags, expected_flags(model_game));
	endtask

	task automatic select_game(input game_id_t g);
		snapshot();
		write_dl(8'(`AI_DL_INDEX_GAME), '0, g);
		settle_and_check(g.name(), 1'b1);
	endtask

	task automatic clear_joysticks();
		usb_joy1 = '0;
		usb_joy2 = '0;
		db_joy1  = '0;
		db_joy2  = '0;
	endtask

	task automatic sweep_controls();
		for (int b = 0; b < 11; b++)
		begin
			snapshot();
			clear_joysticks();
			usb_joy1 = 32'h1 << b;
			settle_and_check($sformatf("usb bit %0d", b), 1'b1);
		end
		snapshot();
		clear_joysticks();
		settle_and_check("release", 1'b1);
	endtask

	// ============================================================
	// Directed tests
	// ============================================================
	task automatic test_game_select();
		game_id_t kept [14] = '{game_scramble, game_frogger, game_scobra, game_armorcar,
			game_tazman, game_calipso, game_anteater, game_losttomb, game_theend,
			game_stratgyx, game_turtles, game_minefld, game_rescue, game_mimonkey};
		foreach (kept[i])
			select_game(kept[i]);
		snapshot();
		write_dl(8'd5, '0, game_tazman);
		settle_and_check("write to index 5", 1'b1);
		snapshot();
		write_dl(8'(`AI_DL_INDEX_DIP), 25'd9, game_calipso);
		settle_and_check("write to DIP index", 1'b1);
	endtask

	task automatic test_mapping();
		game_id_t mapped [4] = '{game_scramble, game_tazman, game_calipso, game_anteater};
		foreach (mapped[i])
		begin
			select_game(mapped[i]);
			sweep_controls();
			for (int n = 0; n < 4; n++)
			begin
				snapshot();
				usb_joy1 = $urandom;
				usb_joy2 = $urandom;
				settle_and_check($sformatf("random usb %0d", n), 1'b1);
			end
			snapshot();
			clear_joysticks();
			settle_and_check("release", 1'b1);
		end
	endtask

	task automatic test_dip_mask();
		select_game(game_scramble);
		for (int b = 0; b < 4; b++)
		begin
			snapshot();
			write_dl(8'(`AI_DL_INDEX_DIP), 25'(b), 8'($urandom));
			settle_and_check($sformatf("DIP byte %0d", b), 1'b1);
		end
		snapshot();
		usb_joy1 = $urandom;
		settle_and_check("masked controls", 1'b1);
		for (int b = 0; b < 4; b++)
		begin
			snapshot();
			write_dl(8'(`AI_DL_INDEX_DIP), 25'(b), 8'hff);
			settle_and_check("DIP restore", 1'b1);
		end
		// Byte 5 is stored but unused, addresses 8 and up are ignored
		snapshot();
		write_dl(8'(`AI_DL_INDEX_DIP), 25'd5, 8'h00);
		settle_and_check("DIP byte 5", 1'b1);
		snapshot();
		write_dl(8'(`AI_DL_INDEX_DIP), 25'd8, 8'h00);
		settle_and_check("DIP address 8", 1'b1);
		snapshot();
		clear_joysticks();
		settle_and_check("release", 1'b1);
	endtask

	task automatic test_alt_fire();
		game_id_t alt_games [2] = '{game_losttomb, game_minefld};
		foreach (alt_games[i])
		begin
			select_game(alt_games[i]);
			for (int a = 1; a >= 0; a--)
			begin
				snapshot();
				alt_fire_mode = a[0];
				settle_and_check("fire mode", 1'b0);
				sweep_controls();
			end
		end
	endtask

	// Losttomb shows every control bit when the fire mode is low
	task automatic test_joystick_source();
		logic [15:0] word;
		select_game(game_losttomb);
		for (int m = 0; m < 3; m++)
			for (int t = 0; t < 2; t++)
			begin
				snapshot();
				db_mode        = db_mode_t'(m);
				db_two_players = t[0];
				clear_joysticks();
				settle_and_check("source select", 1'b1);
				for (int s = 0; s < 4; s++)
					for (int b = 0; b < 13; b++)
					begin
						// Pattern 12 is the start plus C coin combination
						word = (b == 12) ? 16'h0420 : 16'(1 << b);
						snapshot();
						clear_joysticks();
						case (s)
							0: usb_joy1 = {16'h0000, word};
							1: usb_joy2 = {16'h0000, word};
							2: db_joy1 = word;
							default: db_joy2 = word;
						endcase
						settle_and_check($sformatf("mode %0d two %0d src %0d pat %0d",
							m, t, s, b), 1'b1);
					end
			end
		snapshot();
		db_mode = db_off;
		clear_joysticks();
		settle_and_check("source select", 1'b1);
	endtask

	initial
	begin
		void'($urandom(32'hc31c256f));
		rst            = 1'b1;
		db_mode        = db_off;
		db_two_players = 1'b0;
		alt_fire_mode  = 1'b0;
		dl             = '0;
		model_game     = game_scramble;
		clear_joysticks();
		for (int i = 0; i < 4; i++)
			model_dip[i] = `AI_PORT_IDLE;
		repeat (16) @(posedge clk_sys);
		#1;
		rst = 1'b0;
		check_ports("reset", ports, {4{`AI_PORT_IDLE}});
		check_flags("reset", flags, '0);
		test_game_select();
		test_mapping();
		test_dip_mask();
		test_alt_fire();
		test_joystick_source();
		$display("Errors: %0d on ports, %0d on flags", port_errors, flag_errors);
		if (port_errors + flag_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== arcade_input_properties.sv ====
`timescale 1ns/100ps
`include "arcade_input_defs.svh"

module arcade_input_properties
	import arcade_input_pkg::*;
(
	input logic                     clk_sys,
	input logic                     rst,
	input logic [`AI_USB_JOY_W-1:0] usb_joy1,
	input logic [`AI_USB_JOY_W-1:0] usb_joy2,
	input logic [`AI_DB_JOY_W-1:0]  db_joy1,
	input logic [`AI_DB_JOY_W-1:0]  db_joy2,
	input db_mode_t                 db_mode,
	input logic                     db_two_players,
	input logic                     alt_fire_mode,
	input dl_write_t                dl,
	input io_ports_t                ports,
	input board_flags_t             flags
);

	logic game_wr;
	logic dip_wr;
	logic [2*`AI_USB_JOY_W+2*`AI_DB_JOY_W+2:0] joy_in;

	// Hardware select of each game profile
	function automatic logic [7:0] hwsel_of(input logic [7:0] code);
		case (code)
			game_frogger:  return 8'd1;
			game_scobra,
			game_armorcar,
			game_tazman:   return 8'd2;
			game_calipso:  return 8'd3;
			game_stratgyx: return 8'd5;
			game_anteater: return 8'd6;
			game_losttomb: return 8'd7;
			game_minefld:  return 8'd8;
			game_rescue:   return 8'd9;
			game_turtles:  return 8'd11;
			game_mimonkey: return 8'd12;
			default:       return 8'd0;
		endcase
	endfunction

	assign game_wr = dl.wr && (dl.index == 8'(`AI_DL_INDEX_GAME));
	assign dip_wr  = dl.wr && (dl.index == 8'(`AI_DL_INDEX_DIP));
	assign joy_in  = {usb_joy1, usb_joy2, db_joy1, db_joy2, db_mode, db_two_players};

	a_reset_idle: assert property (@(posedge clk_sys)
		$past(rst) |-> (ports == {4{`AI_PORT_IDLE}}))
		else $error("ports not idle during or right after reset");

	a_game_hwsel: assert property (@(posedge clk_sys) disable iff (rst)
		$past(game_wr, 2) && !$past(rst) && !$past(rst, 2)
		|-> (flags.hwsel == hwsel_of($past(dl.data, 2))))
		else $error("hwsel does not match the game written two cycles ago");

	// Controls, game and DIP bytes take two registers, the fire mode only one
	a_port_cause: assert property (@(posedge clk_sys) disable iff (rst)
		!$past(rst) && !$past(rst, 2) && !$past(rst, 3) && (ports != $past(ports))
		|-> ($past(joy_in, 2) != $past(joy_in, 3)) || $past(game_wr, 2) || $past(dip_wr, 2)
			|| ($past(alt_fire_mode) != $past(alt_fire_mode, 2)))
		else $error("ports changed without a matching input change");

endmodule

bind arcade_input_top arcade_input_properties u_props (
	.clk_sys        (clk_sys),
	.rst            (rst),
	.usb_joy1       (usb_joy1),
	.usb_joy2       (usb_joy2),
	.db_joy1        (db_joy1),
	.db_joy2        (db_joy2),
	.db_mode        (db_mode),
	.db_two_players (db_two_players),
	.alt_fire_mode  (alt_fire_mode),
	.dl             (dl),
	.ports          (ports),
	.flags          (flags)
);

// ==== arcade_input_top.sv ====
`timescale 1ns/100ps
`include "arcade_input_defs.svh"

module arcade_input_top
	import arcade_input_pkg::*;
(
	input  logic                     clk_sys,
	input  logic                     rst,
	input  logic [`AI_USB_JOY_W-1:0] usb_joy1,
	input  logic [`AI_USB_JOY_W-1:0] usb_joy2,
	input  logic [`AI_DB_JOY_W-1:0]  db_joy1,
	input  logic [`AI_DB_JOY_W-1:0]  db_joy2,
	input  db_mode_t                 db_mode,
	input  logic                     db_two_players,
	input  logic                     alt_fire_mode,
	input  dl_write_t                dl,
	output io_ports_t                ports,
	output board_flags_t             flags
);

	player_ctrl_t ctrl;
	game_id_t     game;
	io_ports_t    raw_ports;
	board_flags_t raw_flags;

	// Joystick merge plus game register
	control_capture u_capture (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.usb_joy1       (usb_joy1),
		.usb_joy2       (usb_joy2),
		.db_joy1        (db_joy1),
		.db_joy2        (db_joy2),
		.db_mode        (db_mode),
		.db_two_players (db_two_players),
		.dl             (dl),
		.ctrl           (ctrl),
		.game           (game)
	);

	input_port_mapper u_mapper (
		.ctrl          (ctrl),
		.game          (game),
		.alt_fire_mode (alt_fire_mode),
		.raw_ports     (raw_ports),
		.raw_flags     (raw_flags)
	);

	// DIP bank and output registers
	port_output_stage u_output (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.dl        (dl),
		.raw_ports (raw_ports),
		.raw_flags (raw_flags),
		.ports     (ports),
		.flags     (flags)
	);

endmodule

// ==== port_output_stage.sv ====
`timescale 1ns/100ps
`include "arcade_input_defs.svh"

module port_output_stage
	import arcade_input_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst,
	input  dl_write_t    dl,
	input  io_ports_t    raw_ports,
	input  board_flags_t raw_flags,
	output io_ports_t    ports,
	output board_flags_t flags
);

	localparam int DIP_IDX_W = $clog2(`AI_DIP_COUNT);

	logic [`AI_PORT_W-1:0] dip [`AI_DIP_COUNT];
	logic                  dip_wr;

	// ============================================================
	// DIP bank
	// ============================================================

	// Addresses past the bank are ignored
	assign dip_wr = dl.wr && (dl.index == `AI_DL_INDEX_DIP) &&
		(dl.addr[`AI_DL_ADDR_W-1:DIP_IDX_W] == '0);

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			for (int i = 0; i < `AI_DIP_COUNT; i++)
				dip[i] <= '1;
		end
		else if (dip_wr)
		begin
			dip[dl.addr[DIP_IDX_W-1:0]] <= dl.data;
		end
	end

	// ============================================================
	// Masked output registers
	// ============================================================

	// Only bytes 0 to 3 reach the board, a cleared DIP bit pulls the port low
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			ports.pa <= `AI_PORT_IDLE;
			ports.pb <= `AI_PORT_IDLE;
			ports.pc <= `AI_PORT_IDLE;
			ports.pd <= `AI_PORT_IDLE;
			flags    <= '0;
		end
		else
		begin
			ports.pa <= raw_ports.pa & dip[0];
			ports.pb <= raw_ports.pb & dip[1];
			ports.pc <= raw_ports.pc & dip[2];
			ports.pd <= raw_ports.pd & dip[3];
			flags    <= raw_flags;
		end
	end

endmodule

// ==== input_port_mapper.sv ====
`timescale 1ns/100ps
`include "arcade_input_defs.svh"

module input_port_mapper
	import arcade_input_pkg::*;
(
	input  player_ctrl_t ctrl,
	input  game_id_t     game,
	input  logic         alt_fire_mode,
	output io_ports_t    raw_ports,
	output board_flags_t raw_flags
);

	// Ports are active low, so every layout is inverted
	always_comb
	begin
		// Scramble layout is the default for every code
		raw_flags    = '0;
		raw_ports.pa = ~{ctrl.coin, 1'b0, ctrl.left, ctrl.right,
			ctrl.fire_a, 1'b0, ctrl.fire_b, ctrl.up};
		raw_ports.pb = ~{ctrl.start1, ctrl.start2, ctrl.left, ctrl.right,
			ctrl.fire_a, ctrl.fire_b, 2'b00};
		raw_ports.pc = ~{1'b0, ctrl.down, 1'b0, ctrl.up, 3'b000, ctrl.down};
		raw_ports.pd = `AI_PORT_IDLE;

		case (game)
			game_frogger:
				raw_flags.hwsel = 8'd1;
			game_scobra,
			game_armorcar:
				raw_flags.hwsel = 8'd2;
			game_tazman:
			begin
				raw_flags.hwsel = 8'd2;
				raw_ports.pa = ~{ctrl.coin, 1'b0, ctrl.left, ctrl.right,
					ctrl.down, ctrl.up, ctrl.fire_a, ctrl.fire_b};
				raw_ports.pb = `AI_PORT_IDLE;
				raw_ports.pc = ~{1'b0, ctrl.start2, 5'b00000, ctrl.start1};
			end
			game_calipso:
			begin
				raw_flags.hwsel = 8'd3;
				// Fire shares a line with the start buttons
				raw_ports.pa = ~{ctrl.coin, 1'b0, ctrl.left, ctrl.right,
					ctrl.down, ctrl.up, 1'b0, ctrl.start2 | ctrl.fire_a};
				raw_ports.pb = ~{2'b00, ctrl.left, ctrl.right,
					ctrl.down, ctrl.up, 2'b00};
				raw_ports.pc = ~{7'b0000000, ctrl.fire_a | ctrl.start1};
			end
			game_anteater:
			begin
				raw_flags.hwsel = 8'd6;
				raw_ports.pa = ~{ctrl.coin, 1'b0, ctrl.left, ctrl.right,
					ctrl.down, ctrl.up, 1'b0, ctrl.fire_a};
				raw_ports.pb = ~{1'b0, ctrl.fire_a, ctrl.left, ctrl.right,
					ctrl.up, ctrl.down, 2'b00};
				raw_ports.pc = ~{1'b0, ctrl.start2, 5'b00000, ctrl.start1};
			end
			game_losttomb:
			begin
				raw_flags.hwsel     = 8'd7;
				raw_flags.four_fire = 1'b1;
				raw_ports.pa = ~{ctrl.coin, 1'b0, ctrl.left, ctrl.right,
					ctrl.down, ctrl.up, ctrl.start1, ctrl.start2};
				// Second stick either follows movement or carries four fire buttons
				if (alt_fire_mode)
					raw_ports.pb = ~{1'b0, ctrl.fire_e | ctrl.fire_a, ctrl.left,
						ctrl.right, ctrl.down, ctrl.up, 2'b00};
				else
					raw_ports.pb = ~{1'b0, ctrl.fire_e, ctrl.fire_d, ctrl.fire_a,
						ctrl.fire_b, ctrl.fire_c, 2'b00};
				raw_ports.pc = `AI_PORT_IDLE;
			end
			game_theend:
				raw_flags.galaxian_video = 1'b1;
			game_stratgyx:
			begin
				raw_flags.hwsel     = 8'd5;
				raw_flags.landscape = 1'b1;
				raw_ports.pc = ~{ctrl.fire_c, ctrl.down, ctrl.fire_c, ctrl.up,
					3'b000, ctrl.down};
			end
			game_turtles:
			begin
				raw_flags.hwsel = 8'd11;
				raw_ports.pa = ~{ctrl.coin, 1'b0, ctrl.left, ctrl.right,
					ctrl.fire_a, 2'b00, ctrl.up};
				raw_ports.pb = ~{ctrl.start1, ctrl.start2, ctrl.left, ctrl.right,
					ctrl.fire_a, 3'b000};
			end
			game_minefld,
			game_rescue:
			begin
				// Same wiring on both boards, only the select differs
				raw_flags.hwsel     = (game == game_minefld) ? 8'd8 : 8'd9;
				raw_flags.four_fire = 1'b1;
				raw_ports.pa = ~{ctrl.coin, 1'b0, ctrl.left, ctrl.right,
					ctrl.down, ctrl.up, 1'b0, ctrl.start1};
				if (alt_fire_mode)
					raw_ports.pb = ~{2'b00, ctrl.left, ctrl.right,
						ctrl.down, ctrl.up, 2'b00};
				else
					raw_ports.pb = ~{2'b00, ctrl.fire_d, ctrl.fire_a,
						ctrl.fire_b, ctrl.fire_c, 2'b00};
				raw_ports.pc = ~{1'b0, ctrl.start2, 5'b00000, ctrl.start1};
			end
			game_mimonkey:
				raw_flags.hwsel = 8'd12;
			default:
			begin
				// Scramble and unknown codes keep the layout above
			end
		endcase
	end

endmodule

// ==== control_capture.sv ====
`timescale 1ns/100ps
`include "arcade_input_defs.svh"

module control_capture
	import arcade_input_pkg::*;
(
	input  logic                     clk_sys,
	input  logic                     rst,
	input  logic [`AI_USB_JOY_W-1:0] usb_joy1,
	input  logic [`AI_USB_JOY_W-1:0] usb_joy2,
	input  logic [`AI_DB_JOY_W-1:0]  db_joy1,
	input  logic [`AI_DB_JOY_W-1:0]  db_joy2,
	input  db_mode_t                 db_mode,
	input  logic                     db_two_players,
	input  dl_write_t                dl,
	output player_ctrl_t             ctrl,
	output game_id_t                 game
);

	// USB layout: CO S2 S1/F5 F4 F3 F2 F1 U D L R in bits 10 down to 0
	// DB layout: mode/start on 11..8, buttons and stick on 7..0
	function automatic logic [`AI_USB_JOY_W-1:0] map_db(
		input logic [`AI_DB_JOY_W-1:0] db,
		input logic                    second
	);
		logic fire4;
		logic start2;
		logic coin;
		// Second player swaps the two upper buttons
		fire4  = second ? db[9] : db[10];
		start2 = second ? db[10] : db[9];
		// Coin on its own button or as a start+C combination
		coin   = db[11] | (db[10] & db[5]);
		return {{(`AI_USB_JOY_W-11){1'b0}}, coin, start2, fire4, db[7:0]};
	endfunction

	logic                     db_en;
	logic [`AI_USB_JOY_W-1:0] joy_p1;
	logic [`AI_USB_JOY_W-1:0] joy_p2;
	logic [`AI_USB_JOY_W-1:0] joy_any;
	player_ctrl_t             ctrl_next;

	// ============================================================
	// Source select and merge
	// ============================================================
	assign db_en = (db_mode != db_off);

	assign joy_p1 = db_en ? map_db(db_joy1, 1'b0) : usb_joy1;

	// Without a second DB player the first USB stick becomes player 2
	assign joy_p2 = !db_en         ? usb_joy2 :
	                db_two_players ? map_db(db_joy2, 1'b1) : usb_joy1;

	assign joy_any = joy_p1 | joy_p2;

	always_comb
	begin
		ctrl_next        = '0;
		ctrl_next.right  = joy_any[0];
		ctrl_next.left   = joy_any[1];
		ctrl_next.down   = joy_any[2];
		ctrl_next.up     = joy_any[3];
		ctrl_next.fire_a = joy_any[4];
		ctrl_next.fire_b = joy_any[5];
		ctrl_next.fire_c = joy_any[6];
		ctrl_next.fire_d = joy_any[7];
		// Bit 8 doubles as fifth fire and start 1
		ctrl_next.fire_e = joy_any[8];
		ctrl_next.start1 = joy_any[8];
		ctrl_next.start2 = joy_any[9];
		ctrl_next.coin   = joy_any[10];
	end

	// ============================================================
	// Control and game registers
	// ============================================================
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			ctrl <= '0;
			game <= game_scramble;
		end
		else
		begin
			ctrl <= ctrl_next;
			if (dl.wr && (dl.index == `AI_DL_INDEX_GAME))
				game <= game_id_t'(dl.data);
		end
	end

endmodule

// ==== arcade_input_pkg.sv ====
`include "arcade_input_defs.svh"

package arcade_input_pkg;

	// ============================================================
	// Game codes as loaded through download index 1
	// ============================================================
	typedef enum logic [7:0] {
		game_scramble = 8'd0,
		game_amidar   = 8'd1,
		game_frogger  = 8'd2,
		game_scobra   = 8'd3,
		game_tazman   = 8'd4,
		game_armorcar = 8'd5,
		game_moonwar  = 8'd6,
		game_spdcoin  = 8'd7,
		game_calipso  = 8'd8,
		game_darkplnt = 8'd9,
		game_anteater = 8'd10,
		game_losttomb = 8'd11,
		game_theend   = 8'd12,
		game_mars     = 8'd13,
		game_stratgyx = 8'd14,
		game_turtles  = 8'd15,
		game_minefld  = 8'd16,
		game_rescue   = 8'd17,
		game_mimonkey = 8'd18
	} game_id_t;

	// Merged controls of both players, active high
	typedef struct packed {
		logic [1:0] spare;
		logic       coin;
		logic       start2;
		logic       start1;
		logic       fire_e;
		logic       fire_d;
		logic       fire_c;
		logic       fire_b;
		logic       fire_a;
		logic       right;
		logic       left;
		logic       down;
		logic       up;
	} player_ctrl_t;

	// Download write strobe with its index, address and byte
	typedef struct packed {
		logic                     wr;
		logic [7:0]               index;
		logic [`AI_DL_ADDR_W-1:0] addr;
		logic [7:0]               data;
	} dl_write_t;

	// The four active-low input ports of the board
	typedef struct packed {
		logic [`AI_PORT_W-1:0] pa;
		logic [`AI_PORT_W-1:0] pb;
		logic [`AI_PORT_W-1:0] pc;
		logic [`AI_PORT_W-1:0] pd;
	} io_ports_t;

	typedef struct packed {
		logic [7:0] hwsel;
		logic       landscape;
		logic       four_fire;
		logic       galaxian_video;
	} board_flags_t;

	// External reader type, off means USB only
	typedef enum logic [1:0] {
		db_off   = 2'b00,
		db_db15  = 2'b01,
		db_db9md = 2'b10
	} db_mode_t;

endpackage

// ==== arcade_input_defs.svh ====
`ifndef ARCADE_INPUT_DEFS_SVH
`define ARCADE_INPUT_DEFS_SVH

// ============================================================
// Widths
// ============================================================

// One board input port, active low
`define AI_PORT_W 8

// Raw joystick words from the host and from the DB9/DB15 reader
`define AI_USB_JOY_W 32
`define AI_DB_JOY_W 16

// Download write port address
`define AI_DL_ADDR_W 25

// ============================================================
// Download indices and DIP bank
// ============================================================

// Index 1 carries the game code in its data byte
`define AI_DL_INDEX_GAME 1

// Index 254 writes one DIP byte per address
`define AI_DL_INDEX_DIP 254

// Bytes in the DIP bank
`define AI_DIP_COUNT 8

// Port value with nothing pressed
`define AI_PORT_IDLE {`AI_PORT_W{1'b1}}

`endif
